//--- include/step_calc_defs.svh
`ifndef STEP_CALC_DEFS_SVH
`define STEP_CALC_DEFS_SVH

// Channels carried by one frame, at most 256.
`define NUM_CHANNELS 249

// Registered absolute-difference stage.
`define ADDSUB_LATENCY 2

// One divider stage per quotient bit.
`define DIV_LATENCY 8

// Intensity sample to update_rate.
`define CALC_LATENCY (1 + `ADDSUB_LATENCY + 1 + `DIV_LATENCY + 1)

`endif

//--- design/step_calc_pkg.sv
package step_calc_pkg;

  // Channel index, also the address of every per-channel RAM.
  typedef logic [7:0] chan_idx_t;

  // The divider result is produced as one word but consumed as two fields.
  typedef union packed {
    logic [15:0] raw;
    struct packed {
      logic [7:0] quotient;
      logic [7:0] remainder;
    } fields;
  } div_result_u;

endpackage

//--- design/channel_ram.sv
module channel_ram #(
  parameter int WIDTH = 8
) (
  input  logic                     CLK,
  input  logic                     wr_en,
  input  step_calc_pkg::chan_idx_t wr_addr,
  input  logic [WIDTH-1:0]         wr_data,
  input  step_calc_pkg::chan_idx_t rd_addr,
  output logic [WIDTH-1:0]         rd_data
);

  localparam int Depth = 2 ** $bits(step_calc_pkg::chan_idx_t);

  logic [WIDTH-1:0] mem [Depth];

  // Simple dual port with a registered read, one cycle of latency.
  always_ff @(posedge CLK) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
    rd_data <= mem[rd_addr];
  end

endmodule

//--- design/step_divider.sv
`include "step_calc_defs.svh"

module step_divider (
  input  logic                       CLK,
  input  logic [7:0]                 dividend,
  input  logic [7:0]                 divisor,
  output step_calc_pkg::div_result_u result
);

  logic [7:0] rem_q [`DIV_LATENCY];
  logic [7:0] dvd_q [`DIV_LATENCY];
  logic [7:0] dvs_q [`DIV_LATENCY];
  logic [7:0] quo_q [`DIV_LATENCY];

  // Stage i settles quotient bit 7-i. The remaining dividend bits shift out
  // of dvd_q into the partial remainder one per stage.
  for (genvar i = 0; i < `DIV_LATENCY; i++) begin : g_stage
    logic [7:0] rem_in;
    logic [7:0] dvd_in;
    logic [7:0] dvs_in;
    logic [7:0] quo_in;
    logic [8:0] trial;

    if (i == 0) begin : g_first
      assign rem_in = '0;
      assign dvd_in = dividend;
      assign dvs_in = divisor;
      assign quo_in = '0;
    end else begin : g_next
      assign rem_in = rem_q[i-1];
      assign dvd_in = dvd_q[i-1];
      assign dvs_in = dvs_q[i-1];
      assign quo_in = quo_q[i-1];
    end

    assign trial = {rem_in, dvd_in[7]};

    // A zero divisor always subtracts, so the quotient fills with ones
    // and the dividend ends up in the remainder.
    always_ff @(posedge CLK) begin
      if (trial >= {1'b0, dvs_in}) begin
        rem_q[i] <= 8'(trial - {1'b0, dvs_in});
        quo_q[i] <= {quo_in[6:0], 1'b1};
      end else begin
        rem_q[i] <= trial[7:0];
        quo_q[i] <= {quo_in[6:0], 1'b0};
      end
      dvd_q[i] <= {dvd_in[6:0], 1'b0};
      dvs_q[i] <= dvs_in;
    end
  end

  assign result.raw = {quo_q[`DIV_LATENCY-1], rem_q[`DIV_LATENCY-1]};

endmodule

//--- design/step_calculator_intensity.sv
`include "step_calc_defs.svh"

module step_calculator_intensity (
  input  logic                      CLK,
  input  logic                      reset_out,
  input  logic                      din_valid,
  input  logic [7:0]                completion_steps,
  input  logic [7:0]                intensity,
  output logic                      busy,
  output logic [7:0]                update_rate,
  output step_calc_pkg::chan_idx_t  rate_chan,
  output logic [7:0]                new_target,
  output logic                      dout_valid,
  output logic                      frame_done
);

  localparam step_calc_pkg::chan_idx_t Last = `NUM_CHANNELS - 1;
  localparam int Ad = `ADDSUB_LATENCY;
  localparam int Dl = `DIV_LATENCY;

  logic                      running;
  step_calc_pkg::chan_idx_t  cnt, sweep_cnt, in_chan;
  logic                      in_vld;
  logic [7:0]                steps_q;
  logic                      s0_vld;
  step_calc_pkg::chan_idx_t  s0_chan;
  logic [7:0]                s0_int, tgt_rd, diff_rd, rem_rd;
  logic [Ad-1:0]             ad_vld;
  step_calc_pkg::chan_idx_t  ad_chan [Ad];
  logic [7:0]                ad_int [Ad];
  logic [7:0]                diff_a, diff_b, diff_r, dividend;
  logic                      diff_nz;
  logic                      p_vld, p_chg;
  step_calc_pkg::chan_idx_t  p_chan;
  logic [7:0]                p_int;
  logic [Dl-1:0]             dl_vld, dl_chg;
  step_calc_pkg::chan_idx_t  dl_chan [Dl];
  logic [7:0]                dl_int [Dl];
  step_calc_pkg::div_result_u div_res;
  logic                      rem_wr, td_we, rem_we;
  step_calc_pkg::chan_idx_t  rem_wr_chan, td_waddr, rem_waddr;
  logic [7:0]                rem_wr_data, tgt_wdata, dif_wdata, rem_wdata;

  // ====================================================================
  // Frame sequencing and the post-reset clearing sweep
  // ====================================================================
  assign in_vld  = running | (din_valid & ~busy);
  assign in_chan = running ? cnt : '0;

  always_ff @(posedge CLK) begin
    if (reset_out) begin
      busy      <= 1'b1;
      sweep_cnt <= '0;
      running   <= 1'b0;
      cnt       <= '0;
    end else if (busy) begin
      sweep_cnt <= sweep_cnt + 1'b1;
      if (sweep_cnt == Last) begin
        busy <= 1'b0;
      end
    end else if (running) begin
      cnt <= cnt + 1'b1;
      if (cnt == Last) begin
        running <= 1'b0;
      end
    end else if (din_valid) begin
      running <= (`NUM_CHANNELS > 1);
      cnt     <= 8'd1;
    end
  end

  always_ff @(posedge CLK) begin
    if (din_valid & ~busy & ~running) begin
      steps_q <= completion_steps;
    end
  end

  // ====================================================================
  // Pipeline
  // ====================================================================
  assign diff_nz = (diff_r != 8'd0);

  always_ff @(posedge CLK) begin
    if (reset_out) begin
      s0_vld     <= 1'b0;
      ad_vld     <= '0;
      p_vld      <= 1'b0;
      dl_vld     <= '0;
      dout_valid <= 1'b0;
      frame_done <= 1'b0;
      rem_wr     <= 1'b0;
    end else begin
      s0_vld     <= in_vld;
      ad_vld     <= {ad_vld[Ad-2:0], s0_vld};
      p_vld      <= ad_vld[Ad-1];
      dl_vld     <= {dl_vld[Dl-2:0], p_vld};
      dout_valid <= dl_vld[Dl-1];
      frame_done <= dl_vld[Dl-1] & (dl_chan[Dl-1] == Last);
      rem_wr     <= dl_vld[Dl-1];
    end
  end

  always_ff @(posedge CLK) begin
    // The stored target is read while the sample is registered.
    s0_chan <= in_chan;
    s0_int  <= intensity;

    ad_chan[0] <= s0_chan;
    ad_int[0]  <= s0_int;
    for (int i = 1; i < Ad; i++) begin
      ad_chan[i] <= ad_chan[i-1];
      ad_int[i]  <= ad_int[i-1];
    end
    if (s0_int < tgt_rd) begin
      diff_a <= tgt_rd;
      diff_b <= s0_int;
    end else begin
      diff_a <= s0_int;
      diff_b <= tgt_rd;
    end
    diff_r <= diff_a - diff_b;

    // An unchanged target keeps ramping with the last stored difference.
    p_chan   <= ad_chan[Ad-1];
    p_int    <= ad_int[Ad-1];
    p_chg    <= diff_nz;
    dividend <= diff_nz ? diff_r : diff_rd;

    dl_chan[0] <= p_chan;
    dl_int[0]  <= p_int;
    dl_chg     <= {dl_chg[Dl-2:0], p_chg};
    for (int i = 1; i < Dl; i++) begin
      dl_chan[i] <= dl_chan[i-1];
      dl_int[i]  <= dl_int[i-1];
    end

    rate_chan   <= dl_chan[Dl-1];
    new_target  <= dl_int[Dl-1];
    rem_wr_chan <= dl_chan[Dl-1];
    if (dl_chg[Dl-1]) begin
      update_rate <= div_res.fields.quotient;
      rem_wr_data <= div_res.fields.remainder;
    end else if (rem_rd != 8'd0) begin
      // Spend one unit of leftover remainder on this frame.
      update_rate <= div_res.fields.quotient + 1'b1;
      rem_wr_data <= rem_rd - 1'b1;
    end else begin
      update_rate <= div_res.fields.quotient;
      rem_wr_data <= '0;
    end
  end

  // ====================================================================
  // Per-channel state
  // ====================================================================
  assign td_we     = busy | (ad_vld[Ad-1] & diff_nz);
  assign td_waddr  = busy ? sweep_cnt : ad_chan[Ad-1];
  assign tgt_wdata = busy ? 8'd0 : ad_int[Ad-1];
  assign dif_wdata = busy ? 8'd0 : diff_r;
  assign rem_we    = busy | rem_wr;
  assign rem_waddr = busy ? sweep_cnt : rem_wr_chan;
  assign rem_wdata = busy ? 8'd0 : rem_wr_data;

  channel_ram #(.WIDTH(8)) u_targets (
    .CLK     (CLK),
    .wr_en   (td_we),
    .wr_addr (td_waddr),
    .wr_data (tgt_wdata),
    .rd_addr (in_chan),
    .rd_data (tgt_rd)
  );

  channel_ram #(.WIDTH(8)) u_diffs (
    .CLK     (CLK),
    .wr_en   (td_we),
    .wr_addr (td_waddr),
    .wr_data (dif_wdata),
    .rd_addr (ad_chan[Ad-2]),
    .rd_data (diff_rd)
  );

  channel_ram #(.WIDTH(8)) u_remainders (
    .CLK     (CLK),
    .wr_en   (rem_we),
    .wr_addr (rem_waddr),
    .wr_data (rem_wdata),
    .rd_addr (dl_chan[Dl-2]),
    .rd_data (rem_rd)
  );

  step_divider u_divider (
    .CLK      (CLK),
    .dividend (dividend),
    .divisor  (steps_q),
    .result   (div_res)
  );

endmodule

//--- design/rate_buffer.sv
module rate_buffer (
  input  logic                     CLK,
  input  logic                     reset_out,
  input  logic                     rate_wr,
  input  step_calc_pkg::chan_idx_t rate_chan,
  input  logic [7:0]               update_rate,
  input  logic [7:0]               new_target,
  input  logic                     frame_done,
  input  step_calc_pkg::chan_idx_t rd_chan,
  output logic [7:0]               rd_target,
  output logic [7:0]               rd_rate,
  output logic                     rates_fresh
);

  // Bank that the stepper reads from; the calculator fills the other one.
  logic        front;
  logic        loaded;
  logic        front_rd, loaded_rd;
  logic [15:0] bank_rd [2];
  logic [15:0] rd_word;

  for (genvar b = 0; b < 2; b++) begin : g_bank
    channel_ram #(.WIDTH(16)) u_bank (
      .CLK     (CLK),
      .wr_en   (rate_wr & (front != 1'(b))),
      .wr_addr (rate_chan),
      .wr_data ({new_target, update_rate}),
      .rd_addr (rd_chan),
      .rd_data (bank_rd[b])
    );
  end

  always_ff @(posedge CLK) begin
    if (reset_out) begin
      front       <= 1'b0;
      loaded      <= 1'b0;
      front_rd    <= 1'b0;
      loaded_rd   <= 1'b0;
      rates_fresh <= 1'b0;
    end else begin
      if (frame_done) begin
        front  <= ~front;
        loaded <= 1'b1;
      end
      rates_fresh <= frame_done;
      front_rd    <= front;
      loaded_rd   <= loaded;
    end
  end

  assign rd_word   = front_rd ? bank_rd[1] : bank_rd[0];
  assign rd_target = loaded_rd ? rd_word[15:8] : 8'd0;
  assign rd_rate   = loaded_rd ? rd_word[7:0] : 8'd0;

endmodule

//--- design/intensity_stepper.sv
`include "step_calc_defs.svh"

module intensity_stepper (
  input  logic                     CLK,
  input  logic                     reset_out,
  input  logic                     update_tick,
  output step_calc_pkg::chan_idx_t rd_chan,
  input  logic [7:0]               rd_target,
  input  logic [7:0]               rd_rate,
  output logic [7:0]               level,
  output step_calc_pkg::chan_idx_t level_channel,
  output logic                     level_valid
);

  localparam step_calc_pkg::chan_idx_t Last = `NUM_CHANNELS - 1;

  logic                     clearing, active, rd_vld_q, lvl_we;
  step_calc_pkg::chan_idx_t clr_cnt, cnt, rd_chan_q, lvl_waddr;
  logic [7:0]               cur_level, next_level, lvl_wdata;
  logic [8:0]               up_sum;

  assign rd_chan = active ? cnt : '0;

  always_ff @(posedge CLK) begin
    if (reset_out) begin
      clearing    <= 1'b1;
      clr_cnt     <= '0;
      active      <= 1'b0;
      cnt         <= '0;
      rd_vld_q    <= 1'b0;
      level_valid <= 1'b0;
    end else begin
      rd_vld_q    <= active | (update_tick & ~clearing);
      level_valid <= rd_vld_q;
      if (clearing) begin
        clr_cnt <= clr_cnt + 1'b1;
        if (clr_cnt == Last) begin
          clearing <= 1'b0;
        end
      end else if (active) begin
        cnt <= cnt + 1'b1;
        if (cnt == Last) begin
          active <= 1'b0;
        end
      end else if (update_tick) begin
        active <= (`NUM_CHANNELS > 1);
        cnt    <= 8'd1;
      end
    end
  end

  // Move toward the target by the rate and stop exactly on it.
  assign up_sum = {1'b0, cur_level} + {1'b0, rd_rate};

  always_comb begin
    next_level = cur_level;
    if (cur_level < rd_target) begin
      if (up_sum >= {1'b0, rd_target}) begin
        next_level = rd_target;
      end else begin
        next_level = up_sum[7:0];
      end
    end else if (cur_level > rd_target) begin
      if (rd_rate >= cur_level - rd_target) begin
        next_level = rd_target;
      end else begin
        next_level = cur_level - rd_rate;
      end
    end
  end

  always_ff @(posedge CLK) begin
    rd_chan_q     <= rd_chan;
    level         <= next_level;
    level_channel <= rd_chan_q;
  end

  assign lvl_we    = clearing | rd_vld_q;
  assign lvl_waddr = clearing ? clr_cnt : rd_chan_q;
  assign lvl_wdata = clearing ? 8'd0 : next_level;

  channel_ram #(.WIDTH(8)) u_levels (
    .CLK     (CLK),
    .wr_en   (lvl_we),
    .wr_addr (lvl_waddr),
    .wr_data (lvl_wdata),
    .rd_addr (rd_chan),
    .rd_data (cur_level)
  );

endmodule

//--- design/intensity_ramp_top.sv
module intensity_ramp_top (
  input  logic                     CLK,
  input  logic                     reset_out,
  input  logic                     din_valid,
  input  logic [7:0]               completion_steps,
  input  logic [7:0]               intensity,
  input  logic                     update_tick,
  output logic                     busy,
  output logic [7:0]               update_rate,
  output step_calc_pkg::chan_idx_t rate_chan,
  output logic                     dout_valid,
  output logic [7:0]               level,
  output step_calc_pkg::chan_idx_t level_channel,
  output logic                     level_valid
);

  logic [7:0]               new_target;
  logic                     frame_done;
  step_calc_pkg::chan_idx_t rd_chan;
  logic [7:0]               rd_target, rd_rate;

  step_calculator_intensity u_calc (
    .CLK              (CLK),
    .reset_out        (reset_out),
    .din_valid        (din_valid),
    .completion_steps (completion_steps),
    .intensity        (intensity),
    .busy             (busy),
    .update_rate      (update_rate),
    .rate_chan        (rate_chan),
    .new_target       (new_target),
    .dout_valid       (dout_valid),
    .frame_done       (frame_done)
  );

  rate_buffer u_buffer (
    .CLK         (CLK),
    .reset_out   (reset_out),
    .rate_wr     (dout_valid),
    .rate_chan   (rate_chan),
    .update_rate (update_rate),
    .new_target  (new_target),
    .frame_done  (frame_done),
    .rd_chan     (rd_chan),
    .rd_target   (rd_target),
    .rd_rate     (rd_rate),
    .rates_fresh ()
  );

  intensity_stepper u_stepper (
    .CLK           (CLK),
    .reset_out     (reset_out),
    .update_tick   (update_tick),
    .rd_chan       (rd_chan),
    .rd_target     (rd_target),
    .rd_rate       (rd_rate),
    .level         (level),
    .level_channel (level_channel),
    .level_valid   (level_valid)
  );

endmodule

//--- bench/tb_intensity_ramp.sv
`include "step_calc_defs.svh"

module tb_intensity_ramp;

  localparam int NumChannels = `NUM_CHANNELS;
  localparam int BurstLimit  = `NUM_CHANNELS + `CALC_LATENCY + 20;
  localparam int NumFrames   = 7;
  localparam int NumTicks    = 10;

  logic                     CLK;
  logic                     reset_out;
  logic                     din_valid;
  logic [7:0]               completion_steps;
  logic [7:0]               intensity;
  logic                     update_tick;
  logic                     busy;
  logic [7:0]               update_rate;
  step_calc_pkg::chan_idx_t rate_chan;
  logic                     dout_valid;
  logic [7:0]               level;
  step_calc_pkg::chan_idx_t level_channel;
  logic                     level_valid;

  integer seed;
  int     errors;

  // Reference state per channel.
  int m_tgt [256];
  int m_dif [256];
  int m_rem [256];
  int m_lvl [256];
  int fb_tgt [256];
  int fb_rate [256];
  int frame_val [256];

  int chan_q [$];
  int rate_q [$];
  int lchan_q [$];
  int lvl_q [$];

  intensity_ramp_top DUT (
    .CLK              (CLK),
    .reset_out        (reset_out),
    .din_valid        (din_valid),
    .completion_steps (completion_steps),
    .intensity        (intensity),
    .update_tick      (update_tick),
    .busy             (busy),
    .update_rate      (update_rate),
    .rate_chan        (rate_chan),
    .dout_valid       (dout_valid),
    .level            (level),
    .level_channel    (level_channel),
    .level_valid      (level_valid)
  );

  initial begin
    CLK = 1'b0;
    forever #50 CLK = ~CLK;
  end

  // Outputs are registered, so they are steady at the falling edge.
  always @(negedge CLK) begin
    if (dout_valid) begin
      chan_q.push_back(rate_chan);
      rate_q.push_back(update_rate);
    end
    if (level_valid) begin
      lchan_q.push_back(level_channel);
      lvl_q.push_back(level);
    end
  end

  initial begin
    repeat ((NumFrames + NumTicks) * BurstLimit + NumChannels + 4) @(posedge CLK);
    $display("Watchdog expired before the tests finished");
    $display("TB FAILED");
    $finish;
  end

  // ====================================================================
  // Frame and tick helpers
  // ====================================================================
  task automatic wait_burst(input bit use_level, input string what);
    int cycles;
    bit seen;
    bit strobe;
    cycles = 0;
    seen   = 1'b0;
    strobe = use_level ? level_valid : dout_valid;
    while (!(seen && !strobe) && cycles < BurstLimit) begin
      @(negedge CLK);
      strobe = use_level ? level_valid : dout_valid;
      if (strobe) seen = 1'b1;
      cycles++;
    end
    if (!(seen && !strobe)) begin
      errors++;
      $display("%0t: %s burst did not finish within %0d cycles", $time, what, BurstLimit);
    end
  endtask

  task automatic run_frame(input int steps, input int fixed_rate);
    int diff;
    int exp_rate [256];
    diff = 0;
    for (int k = 0; k < NumChannels; k++) begin
      diff = (frame_val[k] > m_tgt[k]) ? frame_val[k] - m_tgt[k] : m_tgt[k] - frame_val[k];
      if (diff != 0) begin
        m_tgt[k]    = frame_val[k];
        m_dif[k]    = diff;
        exp_rate[k] = diff / steps;
        m_rem[k]    = diff % steps;
      end else if (m_rem[k] != 0) begin
        exp_rate[k] = m_dif[k] / steps + 1;
        m_rem[k]    = m_rem[k] - 1;
      end else begin
        exp_rate[k] = m_dif[k] / steps;
      end
      fb_tgt[k]  = frame_val[k];
      fb_rate[k] = exp_rate[k];
    end
    chan_q.delete();
    rate_q.delete();
    @(negedge CLK);
    din_valid        = 1'b1;
    completion_steps = 8'(steps);
    for (int k = 0; k < NumChannels; k++) begin
      intensity = 8'(frame_val[k]);
      @(negedge CLK);
      din_valid = 1'b0;
    end
    intensity = 8'd0;
    wait_burst(1'b0, "dout_valid");
    if (chan_q.size() != NumChannels) begin
      errors++;
      $display("Mismatch at %0t: %0d dout_valid cycles, expected %0d",
               $time, chan_q.size(), NumChannels);
    end
    for (int k = 0; k < chan_q.size() && k < NumChannels; k++) begin
      if (chan_q[k] != k) begin
        errors++;
        $display("Mismatch at %0t: rate_chan %0d at position %0d", $time, chan_q[k], k);
      end
      if (rate_q[k] != exp_rate[k] || (fixed_rate >= 0 && rate_q[k] != fixed_rate)) begin
        errors++;
        $display("Mismatch at %0t: channel %0d rate %0d, expected %0d",
                 $time, k, rate_q[k], exp_rate[k]);
      end
    end
  endtask

  task automatic do_tick(input bit extra);
    int exp_lvl [256];
    for (int k = 0; k < NumChannels; k++) begin
      if (m_lvl[k] < fb_tgt[k]) begin
        m_lvl[k] = (m_lvl[k] + fb_rate[k] >= fb_tgt[k]) ? fb_tgt[k] : m_lvl[k] + fb_rate[k];
      end else if (m_lvl[k] > fb_tgt[k]) begin
        m_lvl[k] = (fb_rate[k] >= m_lvl[k] - fb_tgt[k]) ? fb_tgt[k] : m_lvl[k] - fb_rate[k];
      end
      exp_lvl[k] = m_lvl[k];
    end
    lchan_q.delete();
    lvl_q.delete();
    @(negedge CLK);
    update_tick = 1'b1;
    @(negedge CLK);
    update_tick = 1'b0;
    if (level_valid) begin
      errors++;
      $display("%0t: first level output came 1 cycle after the tick instead of 2", $time);
    end
    @(negedge CLK);
    if (!level_valid) begin
      errors++;
      $display("%0t: first level output did not come 2 cycles after the tick", $time);
    end
    if (extra) begin
      repeat (8) @(negedge CLK);
      update_tick = 1'b1;
      @(negedge CLK);
      update_tick = 1'b0;
    end
    wait_burst(1'b1, "level_valid");
    if (lchan_q.size() != NumChannels) begin
      errors++;
      $display("Mismatch at %0t: %0d level_valid cycles, expected %0d",
               $time, lchan_q.size(), NumChannels);
    end
    for (int k = 0; k < lchan_q.size() && k < NumChannels; k++) begin
      if (lchan_q[k] != k || lvl_q[k] != exp_lvl[k]) begin
        errors++;
        $display("Mismatch at %0t: channel %0d level %0d at position %0d, expected %0d",
                 $time, lchan_q[k], lvl_q[k], k, exp_lvl[k]);
      end
    end
  endtask

  // ====================================================================
  // Directed tests
  // ====================================================================
  task automatic check_busy_ignore();
    int cycles;
    cycles = 0;
    chan_q.delete();
    @(negedge CLK);
    din_valid        = 1'b1;
    completion_steps = 8'd1;
    intensity        = 8'h5a;
    @(negedge CLK);
    din_valid = 1'b0;
    intensity = 8'd0;
    while (busy && cycles < NumChannels + 20) begin
      @(negedge CLK);
      cycles++;
    end
    if (busy) begin
      errors++;
      $display("%0t: busy did not fall after the reset sweep", $time);
    end
    repeat (`CALC_LATENCY + 5) @(negedge CLK);
    if (chan_q.size() != 0) begin
      errors++;
      $display("Mismatch at %0t: %0d dout_valid cycles after a frame sent during busy",
               $time, chan_q.size());
    end
  endtask

  task automatic first_frame_rates();
    for (int k = 0; k < NumChannels; k++) begin
      frame_val[k] = $random(seed) & 8'hff;
    end
    run_frame(1, -1);
    do_tick(1'b0);
  endtask

  // A difference of 10 over 4 steps lands with rates 2, 3, 3, 2.
  task automatic spread_remainder();
    for (int k = 0; k < NumChannels; k++) begin
      frame_val[k] = (frame_val[k] < 128) ? frame_val[k] + 10 : frame_val[k] - 10;
    end
    run_frame(4, 2);
    do_tick(1'b0);
    run_frame(4, 3);
    do_tick(1'b0);
    run_frame(4, 3);
    do_tick(1'b0);
    run_frame(4, 2);
    do_tick(1'b0);
  endtask

  task automatic ramp_downward();
    for (int k = 0; k < NumChannels; k++) begin
      frame_val[k] = frame_val[k] / 2;
    end
    run_frame(3, -1);
    repeat (4) do_tick(1'b0);
  endtask

  initial begin
    seed             = 85;
    errors           = 0;
    reset_out        = 1'b1;
    din_valid        = 1'b0;
    completion_steps = 8'd0;
    intensity        = 8'd0;
    update_tick      = 1'b0;
    for (int k = 0; k < 256; k++) begin
      m_tgt[k]   = 0;
      m_dif[k]   = 0;
      m_rem[k]   = 0;
      m_lvl[k]   = 0;
      fb_tgt[k]  = 0;
      fb_rate[k] = 0;
    end
    repeat (4) @(negedge CLK);
    reset_out = 1'b0;

    check_busy_ignore();
    first_frame_rates();
    spread_remainder();
    ramp_downward();
    // The second tick lands mid-sweep and must be dropped.
    do_tick(1'b1);

    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+include
design/step_calc_pkg.sv
design/channel_ram.sv
design/step_divider.sv
design/step_calculator_intensity.sv
design/rate_buffer.sv
design/intensity_stepper.sv
design/intensity_ramp_top.sv
bench/tb_intensity_ramp.sv

//--- Bender.yml
package:
  name: intensity_ramp

sources:
  - include_dirs:
      - include
    files:
      - design/step_calc_pkg.sv
      - design/channel_ram.sv
      - design/step_divider.sv
      - design/step_calculator_intensity.sv
      - design/rate_buffer.sv
      - design/intensity_stepper.sv
      - design/intensity_ramp_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - bench/tb_intensity_ramp.sv
